// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_mpmc
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The run exits with a nonzero status when the testbench reports a failure
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/mpmc_bus_pkg.sv ====
// ============================================================================
// Memory application bus definitions used along the data path
// ============================================================================

package mpmc_bus_pkg;

	// One address step on the application bus is one strip
	localparam int MEM_ADDR_W = 28;

	// One strip of read data
	localparam int MEM_DATA_W = 32;

	// Strip address as seen by the memory
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	// Read data word returned per strip
	typedef logic [MEM_DATA_W-1:0] mem_data_t;

endpackage

// ==== common/mpmc_ctrl_pkg.sv ====
// ============================================================================
// Controller definitions shared by the FSM, the strip counter and the router
// ============================================================================

package mpmc_ctrl_pkg;

	// Width of a strip count or a strip index
	localparam int STRIP_CNT_W = 6;

	// A request with num_strips equal to n reads n+1 strips, so one request
	// holds from 1 up to 64 strips
	typedef logic [STRIP_CNT_W-1:0] strip_cnt_t;

	// Controller states
	// IDLE        waiting for a start pulse from the arbiter
	// READ_DATA0  one cycle after the grant, arms the strip counter
	// ISSUE       sends one memory command per strip
	// WAIT_DATA   waits for the remaining read beats
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		READ_DATA0 = 3'd1,
		ISSUE      = 3'd2,
		WAIT_DATA  = 3'd3
	} mpmc_state_t;

endpackage

// ==== controller/mpmc_ctrl_fsm.sv ====
`timescale 1ns/100ps

// Per-request controller. It takes one granted request at a time, arms the
// strip counter and then sends one read command per strip to the memory
module mpmc_ctrl_fsm
	import mpmc_bus_pkg::*;
	import mpmc_ctrl_pkg::*;
#(
	parameter int NPORTS = 2,
	localparam int PW = (NPORTS > 1) ? $clog2(NPORTS) : 1
) (
	input  logic          clk,
	input  logic          reset,
	input  logic          start,
	input  logic [PW-1:0] grant_port,
	input  mem_addr_t     grant_addr,
	input  strip_cnt_t    grant_num,
	input  logic          app_rdy,
	input  logic          done,
	output mpmc_state_t   state,
	output logic          idle,
	output logic [PW-1:0] req_port,
	output strip_cnt_t    req_num,
	output logic          app_en,
	output mem_addr_t     app_addr
);

	// Number of commands already accepted by the memory
	strip_cnt_t issued;
	// A command leaves on a cycle where both sides agree
	logic       cmd_take;
	// Set when the accepted command is the final strip of the request
	logic       cmd_last;

	// Idle goes low on the edge after start and is high again from the
	// edge after done
	assign idle = (state == IDLE);

	// Commands are offered for the whole of ISSUE, so app_en holds with
	// app_addr while the memory stalls
	assign app_en = (state == ISSUE);

	assign cmd_take = app_en && app_rdy;
	assign cmd_last = (issued == req_num);

	// ========================================================================
	// State register
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (start)
						state <= READ_DATA0;
				end
				// Counter arms here, no command leaves yet
				READ_DATA0: begin
					state <= ISSUE;
				end
				// Stays as long as the memory stalls or strips remain
				ISSUE: begin
					if (cmd_take && cmd_last)
						state <= WAIT_DATA;
				end
				WAIT_DATA: begin
					if (done)
						state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ========================================================================
	// Request latch and command address
	// ========================================================================

	// Port and count stay fixed until the return to IDLE, so the counter and
	// the router see one request at a time
	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			req_port <= grant_port;
			req_num <= grant_num;
			app_addr <= grant_addr;
			issued <= '0;
		end else if (cmd_take && !cmd_last) begin
			// Only accepted commands move the address on
			app_addr <= app_addr + 1'b1;
			issued <= issued + 1'b1;
		end
	end

endmodule

// ==== controller/mpmc_resp_strip_cnt.sv ====
`timescale 1ns/100ps

// Counts the read beats that return for the current request. The output is
// the index of the beat that arrives in the present cycle
module mpmc_resp_strip_cnt
	import mpmc_ctrl_pkg::*;
(
	input  logic        clk,
	input  mpmc_state_t state,
	input  logic        valid,
	input  strip_cnt_t  num_strips,
	output strip_cnt_t  strip_cnt
);

	// High while beats of the current request are still expected
	logic armed;

	// The controller sits in IDLE during reset, which clears the count too
	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			strip_cnt <= '0;
			armed <= 1'b0;
		end else begin
			if (state == READ_DATA0)
				armed <= 1'b1;
			// Stop counting once the final index has been seen
			if (valid && armed) begin
				if (strip_cnt == num_strips)
					armed <= 1'b0;
				else
					strip_cnt <= strip_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== hw/mpmc_req_arbiter.sv ====
`timescale 1ns/100ps

// Round-robin choice between the client ports. A port holds req, addr and
// num_strips until its ack bit pulses; the grant goes to the controller
// together with a one-cycle start pulse
module mpmc_req_arbiter
	import mpmc_bus_pkg::*;
	import mpmc_ctrl_pkg::*;
#(
	parameter int NPORTS = 2,
	localparam int PW = (NPORTS > 1) ? $clog2(NPORTS) : 1
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     idle,
	input  logic [NPORTS-1:0]        req,
	input  mem_addr_t [NPORTS-1:0]   addr,
	input  strip_cnt_t [NPORTS-1:0]  num_strips,
	output logic [NPORTS-1:0]        ack,
	output logic                     start,
	output logic [PW-1:0]            grant_port,
	output mem_addr_t                grant_addr,
	output strip_cnt_t               grant_num
);

	// Port that received the most recent grant
	logic [PW-1:0] last_port;
	// Winner of the search in this cycle
	logic [PW-1:0] pick;
	logic          found;
	logic          go;

	// Search starts one past the last granted port and wraps around, so the
	// last granted port itself is checked last
	always_comb begin
		int unsigned idx;
		found = 1'b0;
		pick = last_port;
		for (int i = 1; i <= NPORTS; i++) begin
			idx = (int'(last_port) + i) % NPORTS;
			if (!found && req[idx]) begin
				found = 1'b1;
				pick = PW'(idx);
			end
		end
	end

	// Idle is still high in the cycle of start, so a second start is blocked
	assign go = idle && !start && found;

	// ========================================================================
	// Grant registers
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			start <= 1'b0;
			ack <= '0;
			last_port <= '0;
		end else begin
			start <= go;
			ack <= '0;
			if (go) begin
				ack[pick] <= 1'b1;
				last_port <= pick;
			end
		end
	end

	// The granted request travels with the start pulse
	always_ff @(posedge clk) begin
		if (go) begin
			grant_port <= pick;
			grant_addr <= addr[pick];
			grant_num <= num_strips[pick];
		end
	end

endmodule

// ==== hw/mpmc_resp_router.sv ====
`timescale 1ns/100ps

// Output side. Each returned strip is registered with the port that asked
// for it, its index within the request and a last flag
module mpmc_resp_router
	import mpmc_bus_pkg::*;
	import mpmc_ctrl_pkg::*;
#(
	parameter int NPORTS = 2,
	localparam int PW = (NPORTS > 1) ? $clog2(NPORTS) : 1
) (
	input  logic          clk,
	input  logic          reset,
	input  logic          valid,
	input  mem_data_t     data,
	input  strip_cnt_t    strip_cnt,
	input  strip_cnt_t    num_strips,
	input  logic [PW-1:0] req_port,
	output logic          done,
	output logic          resp_valid,
	output logic [PW-1:0] resp_port,
	output strip_cnt_t    resp_strip,
	output mem_data_t     resp_data,
	output logic          resp_last
);

	// Final beat of the request, the one place where the index is compared
	// against the requested count
	logic last_beat;

	assign last_beat = valid && (strip_cnt == num_strips);

	// Completion goes back to the controller in the same cycle as the beat
	assign done = last_beat;

	// ========================================================================
	// Response registers
	// ========================================================================

	// Strobes, one cycle behind the memory
	always_ff @(posedge clk) begin
		if (reset) begin
			resp_valid <= 1'b0;
			resp_last <= 1'b0;
		end else begin
			resp_valid <= valid;
			resp_last <= last_beat;
		end
	end

	// Payload only changes with a beat and is qualified by resp_valid
	always_ff @(posedge clk) begin
		if (valid) begin
			resp_port <= req_port;
			resp_strip <= strip_cnt;
			resp_data <= data;
		end
	end

endmodule

// ==== hw/mpmc_top.sv ====
`timescale 1ns/100ps

// Read path of one controller slice. Client requests pass the arbiter, the
// FSM turns them into memory commands, and returning strips are counted
// and routed back to the clients
module mpmc_top
	import mpmc_bus_pkg::*;
	import mpmc_ctrl_pkg::*;
#(
	parameter int NPORTS = 2,
	localparam int PW = (NPORTS > 1) ? $clog2(NPORTS) : 1
) (
	input  logic                     clk,
	input  logic                     reset,
	// Client request side
	input  logic [NPORTS-1:0]        req,
	input  mem_addr_t [NPORTS-1:0]   addr,
	input  strip_cnt_t [NPORTS-1:0]  num_strips,
	output logic [NPORTS-1:0]        ack,
	// Memory application bus
	output logic                     app_en,
	output mem_addr_t                app_addr,
	input  logic                     app_rdy,
	input  logic                     app_rd_data_valid,
	input  mem_data_t                app_rd_data,
	// Client response side
	output logic                     resp_valid,
	output logic [PW-1:0]            resp_port,
	output strip_cnt_t               resp_strip,
	output mem_data_t                resp_data,
	output logic                     resp_last
);

	// ========================================================================
	// Internal wiring
	// ========================================================================

	// Arbiter to controller
	logic          idle;
	logic          start;
	logic [PW-1:0] grant_port;
	mem_addr_t     grant_addr;
	strip_cnt_t    grant_num;

	// Controller to counter and router
	mpmc_state_t   state;
	logic [PW-1:0] req_port;
	strip_cnt_t    req_num;

	// Counter to router, router back to controller
	strip_cnt_t    strip_cnt;
	logic          done;

	mpmc_req_arbiter #(
		.NPORTS(NPORTS)
	) i_arbiter (
		.clk(clk),
		.reset(reset),
		.idle(idle),
		.req(req),
		.addr(addr),
		.num_strips(num_strips),
		.ack(ack),
		.start(start),
		.grant_port(grant_port),
		.grant_addr(grant_addr),
		.grant_num(grant_num)
	);

	mpmc_ctrl_fsm #(
		.NPORTS(NPORTS)
	) i_ctrl_fsm (
		.clk(clk),
		.reset(reset),
		.start(start),
		.grant_port(grant_port),
		.grant_addr(grant_addr),
		.grant_num(grant_num),
		.app_rdy(app_rdy),
		.done(done),
		.state(state),
		.idle(idle),
		.req_port(req_port),
		.req_num(req_num),
		.app_en(app_en),
		.app_addr(app_addr)
	);

	// Sees the request count that the controller holds
	mpmc_resp_strip_cnt i_strip_cnt (
		.clk(clk),
		.state(state),
		.valid(app_rd_data_valid),
		.num_strips(req_num),
		.strip_cnt(strip_cnt)
	);

	mpmc_resp_router #(
		.NPORTS(NPORTS)
	) i_resp_router (
		.clk(clk),
		.reset(reset),
		.valid(app_rd_data_valid),
		.data(app_rd_data),
		.strip_cnt(strip_cnt),
		.num_strips(req_num),
		.req_port(req_port),
		.done(done),
		.resp_valid(resp_valid),
		.resp_port(resp_port),
		.resp_strip(resp_strip),
		.resp_data(resp_data),
		.resp_last(resp_last)
	);

endmodule

// ==== sources.f ====
common/mpmc_bus_pkg.sv
common/mpmc_ctrl_pkg.sv
hw/mpmc_req_arbiter.sv
controller/mpmc_ctrl_fsm.sv
controller/mpmc_resp_strip_cnt.sv
hw/mpmc_resp_router.sv
hw/mpmc_top.sv
tests/mem_model.sv
tests/tb_mpmc.sv

// ==== tests/mem_model.sv ====
`timescale 1ns/100ps

// Memory stand-in for the application bus. It stalls commands at random and
// returns every accepted command's strip a fixed number of cycles later
module mem_model
	import mpmc_bus_pkg::*;
#(
	parameter int unsigned SEED = 32'h0d2f_13db,
	parameter mem_data_t PATTERN = '0,
	parameter int LATENCY = 4,
	// Cycles out of every four in which app_rdy is high
	parameter int READY_IN_4 = 3
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      app_en,
	input  mem_addr_t app_addr,
	output logic      app_rdy,
	output logic      app_rd_data_valid,
	output mem_data_t app_rd_data
);

	// Read pipeline, stage 0 holds the command taken at the last edge
	logic      pipe_valid [LATENCY];
	mem_data_t pipe_data [LATENCY];

	// The generator is seeded once and drives app_rdy on every falling edge
	initial begin
		app_rdy = 1'b0;
		void'($urandom(SEED));
		forever begin
			@(negedge clk);
			app_rdy = ($urandom % 4) < READY_IN_4;
		end
	end

	// Stored data is the whole strip address mixed with the pattern
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < LATENCY; i++)
				pipe_valid[i] <= 1'b0;
		end else begin
			pipe_valid[0] <= app_en && app_rdy;
			pipe_data[0] <= mem_data_t'(app_addr) ^ PATTERN;
			for (int i = 1; i < LATENCY; i++) begin
				pipe_valid[i] <= pipe_valid[i-1];
				pipe_data[i] <= pipe_data[i-1];
			end
		end
	end

	// Beat is launched on the falling edge so the DUT sees it LATENCY edges
	// after the command was taken
	initial begin
		app_rd_data_valid = 1'b0;
		app_rd_data = '0;
	end
	always @(negedge clk) begin
		app_rd_data_valid <= pipe_valid[LATENCY-1];
		app_rd_data <= pipe_data[LATENCY-1];
	end

endmodule

// ==== tests/tb_mpmc.sv ====
`timescale 1ns/100ps

module tb_mpmc
	import mpmc_bus_pkg::*;
	import mpmc_ctrl_pkg::*;
();

	localparam int NPORTS = 2;
	localparam int PW = 1;
	localparam int CLK_PERIOD = 4;
	localparam int unsigned SEED = 32'h0d2f_13db;
	localparam mem_data_t DATA_PATTERN = 32'h5a3c_96e1;
	// Strips over the run add up from 10, 1 + 64, 4 + 1 + 8 + 16, 6 + 2 + 13 + 3 and 32
	localparam int TOTAL_STRIPS = 160;
	localparam int STALL_MARGIN = 4;
	localparam int SLACK_CYCLES = 600;

	typedef struct packed {
		logic [PW-1:0] port;
		mem_addr_t     addr;
		strip_cnt_t    num;
	} request_t;

	logic clk;
	logic reset;
	logic [NPORTS-1:0] req;
	mem_addr_t [NPORTS-1:0] addr;
	strip_cnt_t [NPORTS-1:0] num_strips;
	logic [NPORTS-1:0] ack;
	logic app_en, app_rdy, app_rd_data_valid;
	mem_addr_t app_addr;
	mem_data_t app_rd_data;
	logic resp_valid, resp_last;
	logic [PW-1:0] resp_port;
	strip_cnt_t resp_strip;
	mem_data_t resp_data;

	// Requests raised per port, then the granted ones in grant order
	request_t port_q [NPORTS][$];
	request_t cmd_q [$];
	request_t rsp_q [$];
	string test_name;
	int cmd_idx = 0;
	int rsp_idx = 0;
	bit have_grant = 1'b0;
	int last_grant = 0;
	// Values seen at the previous rising edge
	logic reset_q = 1'b0;
	logic [NPORTS-1:0] req_q;
	logic en_q, rdy_q;
	mem_addr_t addr_q;

	mpmc_top #(.NPORTS(NPORTS)) i_dut (
		.clk(clk), .reset(reset), .req(req), .addr(addr), .num_strips(num_strips),
		.ack(ack), .app_en(app_en), .app_addr(app_addr), .app_rdy(app_rdy),
		.app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data),
		.resp_valid(resp_valid), .resp_port(resp_port), .resp_strip(resp_strip),
		.resp_data(resp_data), .resp_last(resp_last)
	);

	mem_model #(.SEED(SEED), .PATTERN(DATA_PATTERN), .LATENCY(4)) i_mem (
		.clk(clk), .reset(reset), .app_en(app_en), .app_addr(app_addr),
		.app_rdy(app_rdy),
		.app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data)
	);

	task automatic value_error(string what, logic [63:0] expected, logic [63:0] actual);
		$display("ERR %s %s expected %0h actual %0h", test_name, what, expected, actual);
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic abort_run(string why);
		$display("%s during %s", why, test_name);
		$display(">>> FAIL");
		$fatal(1, "run aborted");
	endtask

	// First pending port after the last granted one, wrapping around
	function automatic int round_robin_pick(logic [NPORTS-1:0] pending, int last);
		int idx;
		for (int i = 1; i <= NPORTS; i++) begin
			idx = (last + i) % NPORTS;
			if (pending[idx])
				return idx;
		end
		return last;
	endfunction

	// Called on a falling edge, returns on the falling edge that shows the ack
	task automatic send_request(int p, mem_addr_t base, strip_cnt_t num);
		request_t r;
		r.port = PW'(p);
		r.addr = base;
		r.num = num;
		port_q[p].push_back(r);
		req[p] = 1'b1;
		addr[p] = base;
		num_strips[p] = num;
		do
			@(negedge clk);
		while (!ack[p]);
		req[p] = 1'b0;
	endtask

	task automatic wait_drained();
		do
			@(negedge clk);
		while (port_q[0].size() + port_q[1].size() + cmd_q.size() + rsp_q.size() != 0);
	endtask

	// ========================================================================
	// Checks
	// ========================================================================

	reset_outputs_low: assert property (@(posedge clk)
		reset_q |-> (ack == '0 && !app_en && !resp_valid && !resp_last))
		else value_error("outputs under reset", '0, {ack, app_en, resp_valid, resp_last});

	// Runs on the rising edge and so sees the values from before the edge
	always @(posedge clk) begin
		request_t r;
		int p;
		p = 0;
		if (!reset && ack != '0) begin
			assert ($onehot(ack)) else value_error("ack one-hot", 1, ack);
			for (int i = 0; i < NPORTS; i++)
				if (ack[i])
					p = i;
			if (have_grant) begin
				assert (p == round_robin_pick(req_q, last_grant))
					else value_error("granted port", round_robin_pick(req_q, last_grant), p);
			end
			have_grant = 1'b1;
			last_grant = p;
			if (port_q[p].size() == 0)
				abort_run("ack pulsed for a port with no request");
			else begin
				r = port_q[p].pop_front();
				cmd_q.push_back(r);
				rsp_q.push_back(r);
			end
		end
		// A stalled command must stay on the bus unchanged
		if (!reset && en_q && !rdy_q) begin
			assert (app_en) else value_error("app_en under stall", 1, app_en);
			assert (app_addr == addr_q)
				else value_error("app_addr under stall", addr_q, app_addr);
		end
		if (!reset && app_en && app_rdy) begin
			if (cmd_q.size() == 0)
				abort_run("memory command taken with no granted request");
			else begin
				r = cmd_q[0];
				assert (app_addr == r.addr + mem_addr_t'(cmd_idx))
					else value_error("command address", r.addr + mem_addr_t'(cmd_idx), app_addr);
				cmd_idx++;
				if (cmd_idx > int'(r.num)) begin
					cmd_idx = 0;
					void'(cmd_q.pop_front());
				end
			end
		end
		if (!reset && resp_valid) begin
			if (rsp_q.size() == 0)
				abort_run("response beat with no outstanding request");
			else begin
				r = rsp_q[0];
				assert (resp_port == r.port) else value_error("resp_port", r.port, resp_port);
				assert (resp_strip == strip_cnt_t'(rsp_idx))
					else value_error("resp_strip", rsp_idx, resp_strip);
				assert (resp_data == (mem_data_t'(r.addr + mem_addr_t'(rsp_idx)) ^ DATA_PATTERN))
					else value_error("resp_data",
						mem_data_t'(r.addr + mem_addr_t'(rsp_idx)) ^ DATA_PATTERN, resp_data);
				assert (resp_last == (rsp_idx == int'(r.num)))
					else value_error("resp_last", rsp_idx == int'(r.num), resp_last);
				rsp_idx++;
				if (rsp_idx > int'(r.num)) begin
					rsp_idx = 0;
					void'(rsp_q.pop_front());
				end
			end
		end
		if (!reset && !resp_valid) begin
			assert (!resp_last) else value_error("resp_last without resp_valid", 0, resp_last);
		end
		reset_q <= reset;
		req_q <= req;
		en_q <= app_en;
		rdy_q <= app_rdy;
		addr_q <= app_addr;
	end

	// ========================================================================
	// Clock, stimulus and watchdog
	// ========================================================================

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((TOTAL_STRIPS * STALL_MARGIN + SLACK_CYCLES) * CLK_PERIOD);
		abort_run("watchdog expired before all requests completed");
	end

	initial begin
		reset = 1'b1;
		req = '0;
		addr = '0;
		num_strips = '0;
		test_name = "reset_state";
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);
		test_name = "single_request";
		send_request(0, 28'h000_1000, 6'd9);
		wait_drained();
		test_name = "edge_counts";
		send_request(1, 28'h0ff_fff0, 6'd0);
		wait_drained();
		send_request(0, 28'h123_4560, 6'd63);
		wait_drained();
		// Both ports keep a request pending so the grants must alternate
		test_name = "two_ports";
		fork
			begin
				send_request(0, 28'h020_0000, 6'd3);
				send_request(0, 28'h020_0100, 6'd0);
				send_request(0, 28'h020_0200, 6'd7);
				send_request(0, 28'h020_0300, 6'd15);
			end
			begin
				send_request(1, 28'h030_0000, 6'd5);
				send_request(1, 28'h030_0100, 6'd1);
				send_request(1, 28'h030_0200, 6'd12);
				send_request(1, 28'h030_0300, 6'd2);
			end
		join
		wait_drained();
		test_name = "back_pressure";
		send_request(1, 28'h7ff_ffc0, 6'd31);
		wait_drained();
		repeat (8) @(negedge clk);
		$display(">>> PASS");
		$finish;
	end

endmodule
